/* verilog/img_win_pkg.sv */
// Widths, window sizes and row buffer states shared by the 3x3 filter RTL and testbench
package img_win_pkg;

    // Pixel and window geometry
    localparam int PIXEL_BITS    = 8;
    localparam int WIN_ROWS      = 3;
    localparam int WIN_COLS      = 3;

    // Line memory sizing
    localparam int MAX_COLS      = 64;
    localparam int COL_ADDR_BITS = 6;

    // Gaussian weights sum to 16
    localparam int KERNEL_SHIFT  = 4;

    // Idle cycles needed between input lines
    localparam int FLUSH_GAP     = 4;

    // row_first, row_last, col_first, col_last, user
    localparam int SIDE_BITS     = 5;

    // Adder widths of the Gaussian stages
    localparam int ROW_SUM_BITS    = PIXEL_BITS + 2;
    localparam int KERNEL_SUM_BITS = PIXEL_BITS + KERNEL_SHIFT;

    // Row buffer flush sequencing
    localparam logic [1:0] RB_IDLE  = 2'd0;
    localparam logic [1:0] RB_WAIT  = 2'd1;
    localparam logic [1:0] RB_FLUSH = 2'd2;

endpackage

/* verilog/img_win_row_buf.sv */
// Row buffer: two line memories turn the pixel stream into vertical 3-pixel columns
`timescale 1ns/100ps

module img_win_row_buf (
    input  logic                                                        clk,
    input  logic                                                        arst_n,
    input  logic                                                        cke,

    input  logic                                                        s_row_first,
    input  logic                                                        s_row_last,
    input  logic                                                        s_col_first,
    input  logic                                                        s_col_last,
    input  logic                                                        s_user,
    input  logic [img_win_pkg::PIXEL_BITS-1:0]                          s_data,
    input  logic                                                        s_valid,

    output logic                                                        m_row_first,
    output logic                                                        m_row_last,
    output logic                                                        m_col_first,
    output logic                                                        m_col_last,
    output logic                                                        m_user,
    output logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::PIXEL_BITS-1:0] m_data,
    output logic                                                        m_valid
);

    // mem0 holds the previous line, mem1 the one before it
    logic [img_win_pkg::PIXEL_BITS-1:0]    mem0 [img_win_pkg::MAX_COLS];
    logic [img_win_pkg::PIXEL_BITS-1:0]    mem1 [img_win_pkg::MAX_COLS];

    logic [1:0]                            state;
    logic                                  out_first;
    logic [img_win_pkg::COL_ADDR_BITS-1:0] wr_col;
    logic [img_win_pkg::COL_ADDR_BITS-1:0] rd_col;
    logic [img_win_pkg::COL_ADDR_BITS-1:0] last_col;
    logic [img_win_pkg::COL_ADDR_BITS-1:0] addr;
    logic                                  flush_user;
    logic                                  frame_end;
    logic                                  flushing;

    logic                                  a_valid;
    logic                                  a_top_rep;
    logic                                  a_bot_rep;
    logic [img_win_pkg::SIDE_BITS-1:0]     a_side;
    logic [img_win_pkg::PIXEL_BITS-1:0]    a_pix;
    logic [img_win_pkg::PIXEL_BITS-1:0]    rd0;
    logic [img_win_pkg::PIXEL_BITS-1:0]    rd1;

    assign flushing  = (state == img_win_pkg::RB_FLUSH);
    assign frame_end = s_valid && s_col_last && s_row_last && (state == img_win_pkg::RB_IDLE);

    // Replay counter during flush, else the write column
    assign addr = flushing ? rd_col : (s_col_first ? '0 : wr_col);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= img_win_pkg::RB_IDLE;
            out_first <= 1'b0;
            wr_col    <= '0;
            rd_col    <= '0;
            a_valid   <= 1'b0;
            m_valid   <= 1'b0;
        end else if (cke) begin
            // The first input line only fills the memory
            a_valid <= (s_valid && !s_row_first) || flushing;
            m_valid <= a_valid;
            if (s_valid) begin
                wr_col <= addr + 1'b1;
                if (s_col_last) begin
                    out_first <= s_row_first;
                end
            end
            case (state)
                img_win_pkg::RB_IDLE: begin
                    if (frame_end) begin
                        state <= img_win_pkg::RB_WAIT;
                    end
                end
                // One idle slot so the column flush of the last line fits
                img_win_pkg::RB_WAIT: begin
                    state  <= img_win_pkg::RB_FLUSH;
                    rd_col <= '0;
                end
                default: begin
                    rd_col <= rd_col + 1'b1;
                    if (rd_col == last_col) begin
                        state <= img_win_pkg::RB_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            if (s_valid && !flushing) begin
                mem0[addr] <= s_data;
                mem1[addr] <= mem0[addr];
            end
            if (frame_end) begin
                last_col   <= addr;
                flush_user <= s_user;
            end
            rd0 <= mem0[addr];
            rd1 <= mem1[addr];

            // Output row is one line behind the input
            a_pix     <= s_data;
            a_top_rep <= out_first;
            a_bot_rep <= flushing;
            if (flushing) begin
                a_side <= {out_first, 1'b1, rd_col == '0, rd_col == last_col, flush_user};
            end else begin
                a_side <= {out_first, 1'b0, s_col_first, s_col_last, s_user};
            end

            m_data[0] <= a_top_rep ? rd0 : rd1;
            m_data[1] <= rd0;
            m_data[2] <= a_bot_rep ? rd0 : a_pix;
            {m_row_first, m_row_last, m_col_first, m_col_last, m_user} <= a_side;
        end
    end

endmodule

/* verilog/img_win_col_buf.sv */
// Column buffer: widens each pixel column into left, centre and right neighbours
`timescale 1ns/100ps

module img_win_col_buf (
    input  logic                                                        clk,
    input  logic                                                        arst_n,
    input  logic                                                        cke,

    input  logic                                                        s_row_first,
    input  logic                                                        s_row_last,
    input  logic                                                        s_col_first,
    input  logic                                                        s_col_last,
    input  logic                                                        s_user,
    input  logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::PIXEL_BITS-1:0] s_data,
    input  logic                                                        s_valid,

    output logic                                                        m_row_first,
    output logic                                                        m_row_last,
    output logic                                                        m_col_first,
    output logic                                                        m_col_last,
    output logic                                                        m_user,
    output logic [img_win_pkg::WIN_COLS-1:0][img_win_pkg::WIN_ROWS-1:0]
                 [img_win_pkg::PIXEL_BITS-1:0]                          m_data,
    output logic                                                        m_valid
);

    logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::PIXEL_BITS-1:0] col_l;
    logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::PIXEL_BITS-1:0] col_c;
    logic [img_win_pkg::SIDE_BITS-1:0]                             side_q;
    logic                                                          flush_pend;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flush_pend <= 1'b0;
            m_valid    <= 1'b0;
        end else if (cke) begin
            // Column 0 is emitted only once column 1 arrives
            m_valid    <= (s_valid && !s_col_first) || flush_pend;
            flush_pend <= s_valid && s_col_last;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            m_data[0] <= col_l;
            m_data[1] <= col_c;
            if (s_valid) begin
                m_data[2] <= s_data;
                // Left edge copies the first column
                col_l     <= s_col_first ? s_data : col_c;
                col_c     <= s_data;
                side_q    <= {s_row_first, s_row_last, s_col_first, s_col_last, s_user};
            end else begin
                // Flush slot, right edge copies the last column
                m_data[2] <= col_c;
            end
            {m_row_first, m_row_last, m_col_first, m_col_last, m_user} <= side_q;
        end
    end

endmodule

/* verilog/img_win_blk.sv */
// Window block: chains row and column buffers into a row-major 3x3 window stream
`timescale 1ns/100ps

module img_win_blk (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       cke,

    input  logic                                       s_row_first,
    input  logic                                       s_row_last,
    input  logic                                       s_col_first,
    input  logic                                       s_col_last,
    input  logic                                       s_user,
    input  logic [img_win_pkg::PIXEL_BITS-1:0]         s_data,
    input  logic                                       s_valid,

    output logic                                       m_row_first,
    output logic                                       m_row_last,
    output logic                                       m_col_first,
    output logic                                       m_col_last,
    output logic                                       m_user,
    output logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::WIN_COLS-1:0]
                 [img_win_pkg::PIXEL_BITS-1:0]         m_data,
    output logic                                       m_valid
);

    logic                                                          rbuf_row_first;
    logic                                                          rbuf_row_last;
    logic                                                          rbuf_col_first;
    logic                                                          rbuf_col_last;
    logic                                                          rbuf_user;
    logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::PIXEL_BITS-1:0] rbuf_data;
    logic                                                          rbuf_valid;
    logic [img_win_pkg::WIN_COLS-1:0][img_win_pkg::WIN_ROWS-1:0]
          [img_win_pkg::PIXEL_BITS-1:0]                            cbuf_data;

    img_win_row_buf u_row_buf (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .s_row_first (s_row_first),
        .s_row_last  (s_row_last),
        .s_col_first (s_col_first),
        .s_col_last  (s_col_last),
        .s_user      (s_user),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .m_row_first (rbuf_row_first),
        .m_row_last  (rbuf_row_last),
        .m_col_first (rbuf_col_first),
        .m_col_last  (rbuf_col_last),
        .m_user      (rbuf_user),
        .m_data      (rbuf_data),
        .m_valid     (rbuf_valid)
    );

    img_win_col_buf u_col_buf (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .s_row_first (rbuf_row_first),
        .s_row_last  (rbuf_row_last),
        .s_col_first (rbuf_col_first),
        .s_col_last  (rbuf_col_last),
        .s_user      (rbuf_user),
        .s_data      (rbuf_data),
        .s_valid     (rbuf_valid),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_user      (m_user),
        .m_data      (cbuf_data),
        .m_valid     (m_valid)
    );

    // Column-major to row-major
    for (genvar y = 0; y < img_win_pkg::WIN_ROWS; y++) begin : g_row
        for (genvar x = 0; x < img_win_pkg::WIN_COLS; x++) begin : g_col
            assign m_data[y][x] = cbuf_data[x][y];
        end
    end

endmodule

/* verilog/img_gauss3x3.sv */
// Two-stage 1-2-1 Gaussian kernel reducing a 3x3 window to one output pixel
`timescale 1ns/100ps

module img_gauss3x3 (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       cke,

    input  logic                                       s_row_first,
    input  logic                                       s_row_last,
    input  logic                                       s_col_first,
    input  logic                                       s_col_last,
    input  logic                                       s_user,
    input  logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::WIN_COLS-1:0]
                 [img_win_pkg::PIXEL_BITS-1:0]         s_data,
    input  logic                                       s_valid,

    output logic                                       m_row_first,
    output logic                                       m_row_last,
    output logic                                       m_col_first,
    output logic                                       m_col_last,
    output logic                                       m_user,
    output logic [img_win_pkg::PIXEL_BITS-1:0]         m_data,
    output logic                                       m_valid
);

    logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::ROW_SUM_BITS-1:0] row_sum;
    logic [img_win_pkg::KERNEL_SUM_BITS-1:0]                         total;
    logic [img_win_pkg::SIDE_BITS-1:0]                               side1;
    logic                                                            valid1;

    // Vertical 1-2-1 over the row sums
    assign total = {2'b00, row_sum[0]} + {1'b0, row_sum[1], 1'b0} + {2'b00, row_sum[2]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid1  <= 1'b0;
            m_valid <= 1'b0;
        end else if (cke) begin
            valid1  <= s_valid;
            m_valid <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            // Stage 1, horizontal 1-2-1 per row
            for (int r = 0; r < img_win_pkg::WIN_ROWS; r++) begin
                row_sum[r] <= {2'b00, s_data[r][0]} + {1'b0, s_data[r][1], 1'b0}
                            + {2'b00, s_data[r][2]};
            end
            side1 <= {s_row_first, s_row_last, s_col_first, s_col_last, s_user};

            // Stage 2, divide by 16
            m_data <= total[img_win_pkg::KERNEL_SHIFT +: img_win_pkg::PIXEL_BITS];
            {m_row_first, m_row_last, m_col_first, m_col_last, m_user} <= side1;
        end
    end

endmodule

/* verilog/img_filter_top.sv */
// Filter top: the window block feeding the Gaussian kernel
`timescale 1ns/100ps

module img_filter_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               cke,

    input  logic                               s_row_first,
    input  logic                               s_row_last,
    input  logic                               s_col_first,
    input  logic                               s_col_last,
    input  logic                               s_user,
    input  logic [img_win_pkg::PIXEL_BITS-1:0] s_data,
    input  logic                               s_valid,

    output logic                               m_row_first,
    output logic                               m_row_last,
    output logic                               m_col_first,
    output logic                               m_col_last,
    output logic                               m_user,
    output logic [img_win_pkg::PIXEL_BITS-1:0] m_data,
    output logic                               m_valid
);

    logic win_row_first;
    logic win_row_last;
    logic win_col_first;
    logic win_col_last;
    logic win_user;
    logic [img_win_pkg::WIN_ROWS-1:0][img_win_pkg::WIN_COLS-1:0]
          [img_win_pkg::PIXEL_BITS-1:0] win_data;
    logic win_valid;

    img_win_blk u_win_blk (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .s_row_first (s_row_first),
        .s_row_last  (s_row_last),
        .s_col_first (s_col_first),
        .s_col_last  (s_col_last),
        .s_user      (s_user),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .m_row_first (win_row_first),
        .m_row_last  (win_row_last),
        .m_col_first (win_col_first),
        .m_col_last  (win_col_last),
        .m_user      (win_user),
        .m_data      (win_data),
        .m_valid     (win_valid)
    );

    img_gauss3x3 u_gauss (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .s_row_first (win_row_first),
        .s_row_last  (win_row_last),
        .s_col_first (win_col_first),
        .s_col_last  (win_col_last),
        .s_user      (win_user),
        .s_data      (win_data),
        .s_valid     (win_valid),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_user      (m_user),
        .m_data      (m_data),
        .m_valid     (m_valid)
    );

endmodule

/* sim/tb_img_filter_top.sv */
// Testbench that streams the golden frame twice through the filter top and checks each output
`timescale 1ns/100ps

module tb_img_filter_top;

    localparam int GOLDEN_WORDS   = 82;
    localparam int FRAME_COUNT    = 2;
    localparam int FRAME_GAP      = img_win_pkg::MAX_COLS + 8;
    localparam int STALL_LIMIT    = 8;
    localparam int OUTPUT_TIMEOUT = 400;
    localparam int TAIL_CYCLES    = 2 * FRAME_GAP;

    logic                               clk;
    logic                               arst_n;
    logic                               cke;

    logic                               s_row_first;
    logic                               s_row_last;
    logic                               s_col_first;
    logic                               s_col_last;
    logic                               s_user;
    logic [img_win_pkg::PIXEL_BITS-1:0] s_data;
    logic                               s_valid;

    logic                               m_row_first;
    logic                               m_row_last;
    logic                               m_col_first;
    logic                               m_col_last;
    logic                               m_user;
    logic [img_win_pkg::PIXEL_BITS-1:0] m_data;
    logic                               m_valid;

    // Header word pair, then one input and expected pixel pair per raster position
    logic [img_win_pkg::PIXEL_BITS-1:0] golden [GOLDEN_WORDS];
    int                                 frame_w;
    int                                 frame_h;
    logic                               cke_was_low;
    int unsigned                        seed_ret;

    img_filter_top uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .cke         (cke),
        .s_row_first (s_row_first),
        .s_row_last  (s_row_last),
        .s_col_first (s_col_first),
        .s_col_last  (s_col_last),
        .s_user      (s_user),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_user      (m_user),
        .m_data      (m_data),
        .m_valid     (m_valid)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name,
                               input logic [img_win_pkg::PIXEL_BITS-1:0] expected,
                               input logic [img_win_pkg::PIXEL_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // Repeats the beat until a cycle with cke high takes it
    task automatic send_beat(input logic valid, input logic row_first, input logic row_last,
                             input logic col_first, input logic col_last, input logic user,
                             input logic [img_win_pkg::PIXEL_BITS-1:0] data);
        int tries;
        tries = 0;
        do begin
            @(negedge clk);
            if (tries >= STALL_LIMIT) begin
                $display("Timeout: clock enable stayed low and an input beat was never taken");
                stop_run();
            end
            // Never two stall cycles in a row
            cke         = cke_was_low || (($urandom % 6) != 0);
            cke_was_low = !cke;
            s_valid     = valid;
            s_row_first = row_first;
            s_row_last  = row_last;
            s_col_first = col_first;
            s_col_last  = col_last;
            s_user      = user;
            s_data      = data;
            tries++;
        end while (!cke);
    endtask

    task automatic send_idle(input int beats);
        for (int i = 0; i < beats; i++) begin
            send_beat(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic stream_frames();
        int idx;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            for (int r = 0; r < frame_h; r++) begin
                for (int c = 0; c < frame_w; c++) begin
                    idx = 2 + 2 * (r * frame_w + c);
                    send_beat(1'b1, r == 0, r == frame_h - 1, c == 0, c == frame_w - 1,
                              f == 1, golden[idx]);
                end
                send_idle(img_win_pkg::FLUSH_GAP);
            end
            send_idle(FRAME_GAP);
        end
    endtask

    // cke sampled at the rising edge and outputs read at the falling edge
    task automatic wait_output(input int frame, input int row, input int col);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = cke;
            @(negedge clk);
            taken = taken && (m_valid === 1'b1);
            if (!taken) begin
                waited++;
                if (waited > OUTPUT_TIMEOUT) begin
                    $display("Timeout: output row %0d column %0d of frame %0d never arrived",
                             row, col, frame);
                    stop_run();
                end
            end
        end
    endtask

    task automatic check_outputs();
        int idx;
        for (int f = 0; f < FRAME_COUNT; f++) begin
            for (int r = 0; r < frame_h; r++) begin
                for (int c = 0; c < frame_w; c++) begin
                    wait_output(f, r, c);
                    idx = 3 + 2 * (r * frame_w + c);
                    check_pixel("m_data", golden[idx], m_data);
                    check_flag("m_row_first", r == 0, m_row_first);
                    check_flag("m_row_last", r == frame_h - 1, m_row_last);
                    check_flag("m_col_first", c == 0, m_col_first);
                    check_flag("m_col_last", c == frame_w - 1, m_col_last);
                    check_flag("m_user", f == 1, m_user);
                end
            end
        end
    endtask

    // Nothing may follow the last pixel of the final frame
    task automatic check_tail();
        logic en;
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(posedge clk);
            en = cke;
            @(negedge clk);
            if (en && (m_valid !== 1'b0)) begin
                $display("Unexpected output after the last pixel of the final frame");
                stop_run();
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        cke         = 1'b1;
        s_row_first = 1'b0;
        s_row_last  = 1'b0;
        s_col_first = 1'b0;
        s_col_last  = 1'b0;
        s_user      = 1'b0;
        s_data      = '0;
        s_valid     = 1'b0;
        cke_was_low = 1'b0;
        seed_ret    = $urandom(49);

        $readmemh("sim/img_filter_golden.txt", golden);
        frame_w = int'(golden[0]);
        frame_h = int'(golden[1]);
        if (frame_w < 2 || frame_w > img_win_pkg::MAX_COLS || frame_h < 2
                || 2 + 2 * frame_w * frame_h != GOLDEN_WORDS) begin
            $display("Golden file header does not match its frame size or pixel count");
            stop_run();
        end

        // Outputs stay quiet during reset
        repeat (8) begin
            @(negedge clk);
            check_flag("m_valid", 1'b0, m_valid);
        end
        arst_n = 1'b1;

        fork
            begin
                send_idle(3);
                stream_frames();
            end
            begin
                check_outputs();
                check_tail();
            end
        join

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim/img_filter_golden.txt */
// Hex columns: input pixel, expected Gaussian output with replicated borders (raster order)
// First data line holds the frame width and height
08 05
// row 0
0a 3a
14 3c
1e 3e
28 41
32 43
3c 46
46 48
50 4a
// row 1
c8 64
b4 6e
a0 87
8c 7f
78 58
64 49
50 51
3c 53
// row 2
00 3d
00 59
ff 94
ff 8f
00 4a
00 35
80 50
80 5c
// row 3
32 48
32 48
32 68
32 68
32 48
32 40
32 50
32 48
// row 4
ff 9b
00 6c
ff 6c
00 6c
ff 6c
00 6c
ff 6c
00 3c

/* img_filter_top.f */
verilog/img_win_pkg.sv
verilog/img_win_row_buf.sv
verilog/img_win_col_buf.sv
verilog/img_win_blk.sv
verilog/img_gauss3x3.sv
verilog/img_filter_top.sv
sim/tb_img_filter_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the filter testbench with Verilator, run it and check for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps \
        --top-module tb_img_filter_top -Mdir obj_dir -f img_filter_top.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_img_filter_top 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
